/* hw/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// --------------------------------------------------
// Core widths and memory sizes
// --------------------------------------------------
`define CORE_XLEN        32              // Data and address width
`define CORE_REG_AW      5               // Register index width
`define CORE_IMEM_WORDS  256             // Instruction memory depth in words
`define CORE_DMEM_WORDS  256             // Data memory depth in words

// --------------------------------------------------
// Memory-mapped locations
// --------------------------------------------------
`define CORE_IO_LEDR_ADDR  32'h1001_0000 // Red LED register, one word
`define CORE_HALT_ADDR     32'hFFFF_FFFC // Store here stops the core

`endif

/* hw/core_top.sv */
`include "core_params.svh"

module core_top (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_imem_we,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] i_imem_addr,
    input  logic [`CORE_XLEN-1:0]               i_imem_wdata,
    output logic [`CORE_XLEN-1:0]               o_io_ledr,
    output logic [`CORE_XLEN-1:0]               o_pc_frontend,  // IF/ID PC
    output logic [`CORE_XLEN-1:0]               o_pc_commit,
    output logic                                o_insn_vld,
    output logic                                o_halt
);

    isa_pkg::insn_u     if_insn;
    logic               if_valid;
    logic               stall;
    pipe_pkg::fwd_sel_e fwd_a, fwd_b;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();
    wb_if     wb_bus ();

    // --------------------------------------------------
    // Stages
    // --------------------------------------------------
    fetch_stage u_fetch (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_stall      (stall),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .i_halt       (o_halt),         // Freeze front end once halted
        .o_if_pc      (o_pc_frontend),
        .o_if_insn    (if_insn),
        .o_if_valid   (if_valid)
    );

    decode_stage u_decode (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (stall),
        .i_pc    (o_pc_frontend),
        .i_insn  (if_insn),
        .i_valid (if_valid),
        .wb      (wb_bus.regfile_dst),
        .id_ex   (id_ex_bus.decode_src)
    );

    execute_stage u_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_fwd_a (fwd_a),
        .i_fwd_b (fwd_b),
        .id_ex   (id_ex_bus.execute_dst),
        .wb      (wb_bus.fwd_mon),
        .ex_mem  (ex_mem_bus.execute_src)
    );

    mem_wb_stage u_mem_wb (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .ex_mem      (ex_mem_bus.memory_dst),
        .wb          (wb_bus.writeback_src),
        .o_io_ledr   (o_io_ledr),
        .o_pc_commit (o_pc_commit),
        .o_insn_vld  (o_insn_vld),
        .o_halt      (o_halt)
    );

    // Stall and forward control
    hazard_unit u_hazard (
        .i_if_insn (if_insn),
        .id_ex     (id_ex_bus.hazard_mon),
        .ex_mem    (ex_mem_bus.fwd_mon),
        .wb        (wb_bus.fwd_mon),
        .o_stall   (stall),
        .o_fwd_a   (fwd_a),
        .o_fwd_b   (fwd_b)
    );

endmodule

/* hw/decode_stage.sv */
`include "core_params.svh"

module decode_stage (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic [`CORE_XLEN-1:0] i_pc,
    input  isa_pkg::insn_u        i_insn,
    input  logic                  i_valid,
    wb_if.regfile_dst             wb,
    id_ex_if.decode_src           id_ex
);

    logic [`CORE_XLEN-1:0]   rf [1:2**`CORE_REG_AW-1];  // x0 not stored
    logic                    rf_we;
    logic [`CORE_REG_AW-1:0] rs1, rs2;
    logic [`CORE_XLEN-1:0]   rs1_val, rs2_val;
    logic [`CORE_XLEN-1:0]   imm;
    pipe_pkg::ctrl_t         ctrl;

    // Funct3/funct7 to ALU op, SUB only exists in the register form
    function automatic pipe_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                     input logic sub_ok);
        case (f3)
            isa_pkg::F3_ADD_SUB: return (alt && sub_ok) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     return pipe_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     return pipe_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    return pipe_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     return pipe_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: return alt ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
            isa_pkg::F3_OR:      return pipe_pkg::ALU_OR;
            default:             return pipe_pkg::ALU_AND;
        endcase
    endfunction

    // --------------------------------------------------
    // Decoder
    // --------------------------------------------------
    always_comb begin
        ctrl       = '0;
        imm        = '0;
        ctrl.valid = i_valid;
        case (i_insn.r.opcode)
            isa_pkg::OP: begin
                ctrl.wb_en  = 1'b1;
                ctrl.alu_op = alu_decode(i_insn.r.funct3, i_insn.r.funct7 == isa_pkg::F7_ALT,
                                         1'b1);
            end
            isa_pkg::OP_IMM: begin
                ctrl.wb_en   = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = alu_decode(i_insn.i.funct3, i_insn.r.funct7 == isa_pkg::F7_ALT,
                                          1'b0);  // imm[11:5] only matters for SRAI
                imm = {{(`CORE_XLEN-12){i_insn.i.imm[11]}}, i_insn.i.imm};
            end
            isa_pkg::LUI: begin
                ctrl.wb_en   = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.is_lui  = 1'b1;  // 0 + imm through the adder
                imm = {i_insn.u.imm, 12'b0};
            end
            isa_pkg::LOAD: begin
                ctrl.wb_en    = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.use_imm  = 1'b1;
                imm = {{(`CORE_XLEN-12){i_insn.i.imm[11]}}, i_insn.i.imm};
            end
            isa_pkg::STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm = {{(`CORE_XLEN-12){i_insn.s.imm_hi[6]}}, i_insn.s.imm_hi, i_insn.s.imm_lo};
            end
            default: ;  // Unknown opcode runs as a no-op
        endcase
        if (!i_valid) ctrl = '0;
    end

    // --------------------------------------------------
    // Register file
    // --------------------------------------------------
    assign rs1   = i_insn.r.rs1;
    assign rs2   = i_insn.r.rs2;
    assign rf_we = wb.valid && wb.wb_en && (wb.rd != '0);

    always_ff @(posedge i_clk) begin
        if (rf_we) rf[wb.rd] <= wb.data;
    end

    // Same-cycle write shows through on the read ports
    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : rf[rs1];
        rs2_val = (rs2 == '0) ? '0 : rf[rs2];
        if (rf_we && wb.rd == rs1) rs1_val = wb.data;
        if (rf_we && wb.rd == rs2) rs2_val = wb.data;
    end

    // ID/EX register, bubble while stalled
    always_ff @(posedge i_clk) begin
        if (!i_reset || i_stall) id_ex.ctrl <= '0;
        else                     id_ex.ctrl <= ctrl;
    end

    always_ff @(posedge i_clk) begin
        id_ex.pc      <= i_pc;
        id_ex.rs1     <= rs1;
        id_ex.rs2     <= rs2;
        id_ex.rd      <= i_insn.r.rd;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= imm;
    end

endmodule

/* hw/execute_stage.sv */
`include "core_params.svh"

module execute_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    input  pipe_pkg::fwd_sel_e i_fwd_a,
    input  pipe_pkg::fwd_sel_e i_fwd_b,
    id_ex_if.execute_dst       id_ex,
    wb_if.fwd_mon              wb,
    ex_mem_if.execute_src      ex_mem
);

    logic [`CORE_XLEN-1:0] rs1_fwd, rs2_fwd;  // After forwarding
    logic [`CORE_XLEN-1:0] op_a, op_b;
    logic [`CORE_XLEN-1:0] alu_y;
    logic [4:0]            shamt;

    function automatic logic [`CORE_XLEN-1:0] fwd_mux(input pipe_pkg::fwd_sel_e sel,
                                                      input logic [`CORE_XLEN-1:0] rf_val,
                                                      input logic [`CORE_XLEN-1:0] exm_val,
                                                      input logic [`CORE_XLEN-1:0] wb_val);
        case (sel)
            pipe_pkg::FWD_EXM: return exm_val;
            pipe_pkg::FWD_MWB: return wb_val;
            default:           return rf_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(i_fwd_a, id_ex.rs1_val, ex_mem.alu_result, wb.data);
    assign rs2_fwd = fwd_mux(i_fwd_b, id_ex.rs2_val, ex_mem.alu_result, wb.data);
    assign op_a    = id_ex.ctrl.is_lui  ? '0        : rs1_fwd;
    assign op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::ALU_ADD:  alu_y = op_a + op_b;
            pipe_pkg::ALU_SUB:  alu_y = op_a - op_b;
            pipe_pkg::ALU_SLL:  alu_y = op_a << shamt;
            pipe_pkg::ALU_SLT:  alu_y = `CORE_XLEN'($signed(op_a) < $signed(op_b));
            pipe_pkg::ALU_SLTU: alu_y = `CORE_XLEN'(op_a < op_b);
            pipe_pkg::ALU_XOR:  alu_y = op_a ^ op_b;
            pipe_pkg::ALU_SRL:  alu_y = op_a >> shamt;
            pipe_pkg::ALU_SRA:  alu_y = $signed(op_a) >>> shamt;  // Arithmetic
            pipe_pkg::ALU_OR:   alu_y = op_a | op_b;
            default:            alu_y = op_a & op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (!i_reset) ex_mem.ctrl <= '0;
        else          ex_mem.ctrl <= id_ex.ctrl;
    end

    always_ff @(posedge i_clk) begin
        ex_mem.pc         <= id_ex.pc;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_result <= alu_y;
        ex_mem.store_data <= rs2_fwd;  // SW data needs the forwarded rs2 too
    end

endmodule

/* hw/fetch_stage.sv */
`include "core_params.svh"

module fetch_stage (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_stall,
    input  logic                                i_imem_we,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] i_imem_addr,
    input  logic [`CORE_XLEN-1:0]               i_imem_wdata,
    input  logic                                i_halt,
    output logic [`CORE_XLEN-1:0]               o_if_pc,
    output isa_pkg::insn_u                      o_if_insn,
    output logic                                o_if_valid
);

    localparam int IMEM_AW = $clog2(`CORE_IMEM_WORDS);

    logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_WORDS];
    logic [`CORE_XLEN-1:0] pc_q;
    logic                  hold;

    assign hold = i_stall | i_halt;  // Load-use or halted

    // Program load port, one word per clock
    always_ff @(posedge i_clk) begin
        if (i_imem_we) imem[i_imem_addr] <= i_imem_wdata;
    end

    // PC and IF/ID valid
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            pc_q       <= '0;
            o_if_valid <= 1'b0;
        end else if (!hold) begin
            pc_q       <= pc_q + `CORE_XLEN'd4;
            o_if_valid <= 1'b1;
        end
    end

    // IF/ID payload
    always_ff @(posedge i_clk) begin
        if (i_reset && !hold) begin
            o_if_pc   <= pc_q;
            o_if_insn <= imem[pc_q[IMEM_AW+1:2]];  // Word index, upper bits dropped
        end
    end

endmodule

/* hw/hazard_unit.sv */
`include "core_params.svh"

module hazard_unit (
    input  isa_pkg::insn_u     i_if_insn,
    id_ex_if.hazard_mon        id_ex,
    ex_mem_if.fwd_mon          ex_mem,
    wb_if.fwd_mon              wb,
    output logic               o_stall,
    output pipe_pkg::fwd_sel_e o_fwd_a,
    output pipe_pkg::fwd_sel_e o_fwd_b
);

    logic exm_ok, wb_ok;  // Source may forward

    // EX/MEM wins over MEM/WB, x0 never forwards
    function automatic pipe_pkg::fwd_sel_e fwd_pick(input logic [`CORE_REG_AW-1:0] rs,
                                                    input logic [`CORE_REG_AW-1:0] exm_rd,
                                                    input logic exm_en,
                                                    input logic [`CORE_REG_AW-1:0] wb_rd,
                                                    input logic wb_en);
        if (rs == '0)                  return pipe_pkg::FWD_RF;
        else if (exm_en && exm_rd == rs) return pipe_pkg::FWD_EXM;
        else if (wb_en && wb_rd == rs)   return pipe_pkg::FWD_MWB;
        else                           return pipe_pkg::FWD_RF;
    endfunction

    assign exm_ok = ex_mem.ctrl.valid && ex_mem.ctrl.wb_en;
    assign wb_ok  = wb.valid && wb.wb_en;

    assign o_fwd_a = fwd_pick(id_ex.rs1, ex_mem.rd, exm_ok, wb.rd, wb_ok);
    assign o_fwd_b = fwd_pick(id_ex.rs2, ex_mem.rd, exm_ok, wb.rd, wb_ok);

    // Load in ID/EX feeding the instruction in IF/ID, one bubble
    assign o_stall = id_ex.ctrl.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                     ((id_ex.rd == i_if_insn.r.rs1) || (id_ex.rd == i_if_insn.r.rs2));

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,  // LW only
        STORE  = 7'b0100011   // SW only
    } opcode_e;

    // ALU funct3 encodings, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA/SRAI

    // Field layouts, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;     // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word seen through every format at once
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } insn_u;

endpackage

/* hw/mem_wb_stage.sv */
`include "core_params.svh"

module mem_wb_stage (
    input  logic                  i_clk,
    input  logic                  i_reset,
    ex_mem_if.memory_dst          ex_mem,
    wb_if.writeback_src           wb,
    output logic [`CORE_XLEN-1:0] o_io_ledr,
    output logic [`CORE_XLEN-1:0] o_pc_commit,
    output logic                  o_insn_vld,
    output logic                  o_halt
);

    localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];
    logic [DMEM_AW-1:0]    dmem_idx;
    logic                  is_led, is_halt;
    logic                  st_ok;      // Store allowed this cycle
    logic                  halt_hit;   // Halt store committing now
    logic                  halt_q;
    logic [`CORE_XLEN-1:0] ledr_q;
    logic [`CORE_XLEN-1:0] rdata;

    // MEM/WB register
    pipe_pkg::ctrl_t         mwb_ctrl;
    logic [`CORE_XLEN-1:0]   mwb_pc;
    logic [`CORE_XLEN-1:0]   mwb_alu;
    logic [`CORE_XLEN-1:0]   mwb_rdata;
    logic [`CORE_REG_AW-1:0] mwb_rd;

    // --------------------------------------------------
    // Address decode and memory
    // --------------------------------------------------
    assign is_led   = ex_mem.alu_result == `CORE_IO_LEDR_ADDR;
    assign is_halt  = ex_mem.alu_result == `CORE_HALT_ADDR;
    assign dmem_idx = ex_mem.alu_result[DMEM_AW+1:2];  // Truncated word index
    assign halt_hit = mwb_ctrl.valid && mwb_ctrl.mem_write && (mwb_alu == `CORE_HALT_ADDR);
    assign st_ok    = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write && !halt_q && !halt_hit;

    always_ff @(posedge i_clk) begin
        if (st_ok && !is_led && !is_halt) dmem[dmem_idx] <= ex_mem.store_data;
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset)            ledr_q <= '0;
        else if (st_ok && is_led) ledr_q <= ex_mem.store_data;
    end

    assign rdata = is_led ? ledr_q : dmem[dmem_idx];  // LED reads back

    always_ff @(posedge i_clk) begin
        if (!i_reset) mwb_ctrl <= '0;
        else          mwb_ctrl <= ex_mem.ctrl;
    end

    always_ff @(posedge i_clk) begin
        mwb_pc    <= ex_mem.pc;
        mwb_alu   <= ex_mem.alu_result;
        mwb_rdata <= rdata;
        mwb_rd    <= ex_mem.rd;
    end

    // --------------------------------------------------
    // Write-back, halt and commit
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset)      halt_q <= 1'b0;
        else if (halt_hit) halt_q <= 1'b1;  // Sticky until reset
    end

    assign wb.valid = mwb_ctrl.valid && !halt_q;
    assign wb.wb_en = mwb_ctrl.wb_en;
    assign wb.rd    = mwb_rd;
    assign wb.data  = mwb_ctrl.mem_read ? mwb_rdata : mwb_alu;

    assign o_io_ledr   = ledr_q;
    assign o_pc_commit = mwb_pc;
    assign o_insn_vld  = mwb_ctrl.valid && !halt_q;
    assign o_halt      = halt_q;

endmodule

/* hw/pipe_if.sv */
`include "core_params.svh"

// --------------------------------------------------
// Decode to execute
// --------------------------------------------------
interface id_ex_if;
    logic [`CORE_XLEN-1:0]   pc;
    pipe_pkg::ctrl_t         ctrl;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   rs1_val;
    logic [`CORE_XLEN-1:0]   rs2_val;
    logic [`CORE_XLEN-1:0]   imm;

    modport decode_src  (output pc, ctrl, rs1, rs2, rd, rs1_val, rs2_val, imm);
    modport execute_dst (input pc, ctrl, rd, rs1_val, rs2_val, imm);
    modport hazard_mon  (input ctrl, rs1, rs2, rd);  // Load-use and forward compare
endinterface

// --------------------------------------------------
// Execute to memory
// --------------------------------------------------
interface ex_mem_if;
    logic [`CORE_XLEN-1:0]   pc;
    pipe_pkg::ctrl_t         ctrl;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   alu_result;   // Also the load/store address
    logic [`CORE_XLEN-1:0]   store_data;

    modport execute_src (output pc, ctrl, rd, alu_result, store_data);
    modport memory_dst  (input pc, ctrl, rd, alu_result, store_data);
    modport fwd_mon     (input ctrl, rd);
endinterface

// Write-back port, back to the register file and the forward paths
interface wb_if;
    logic                    valid;
    logic                    wb_en;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   data;

    modport writeback_src (output valid, wb_en, rd, data);
    modport regfile_dst   (input valid, wb_en, rd, data);
    modport fwd_mon       (input valid, wb_en, rd, data);
endinterface

/* hw/pipe_pkg.sv */
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // Also address calc and LUI pass-through
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,  // Value read in decode
        FWD_EXM = 2'd1,  // EX/MEM ALU result
        FWD_MWB = 2'd2   // MEM/WB write-back data
    } fwd_sel_e;

    // Per-instruction control, all zero is a bubble
    typedef struct packed {
        logic    valid;
        logic    wb_en;
        logic    mem_read;
        logic    mem_write;
        alu_op_e alu_op;
        logic    use_imm;   // Operand B from immediate
        logic    is_lui;    // Operand A forced to zero
    } ctrl_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_core_top \
    -Mdir obj_dir -o sim_core
./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* test/tb_core_top.sv */
`include "core_params.svh"

module tb_core_top;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          PAD_WORDS    = 8;    // LED stores behind the halt, must stay blocked
    localparam int          POST_HALT    = 10;   // Cycles watched once halted
    localparam int          MAX_WORDS    = `CORE_IMEM_WORDS;
    localparam int          IMEM_AW      = $clog2(`CORE_IMEM_WORDS);
    localparam logic [31:0] LED_ADDR     = `CORE_IO_LEDR_ADDR;
    localparam logic [31:0] HALT_ADDR    = `CORE_HALT_ADDR;

    // --------------------------------------------------
    // RV32I encodings
    // --------------------------------------------------
    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_LD  = 7'b0000011;
    localparam logic [6:0] OPC_ST  = 7'b0100011;
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;  // SUB and SRA
    localparam logic [2:0] F3_ADD  = 3'd0;
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;   // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;
    localparam logic [2:0] F3_WORD = 3'd2;   // LW and SW

    logic               i_clk;
    logic               i_reset;
    logic               i_imem_we;
    logic [IMEM_AW-1:0] i_imem_addr;
    logic [31:0]        i_imem_wdata;
    logic [31:0]        o_io_ledr;
    logic [31:0]        o_pc_frontend;
    logic [31:0]        o_pc_commit;
    logic               o_insn_vld;
    logic               o_halt;

    // Program table with the expected LED value per row
    logic [31:0] prog_word [MAX_WORDS];
    logic        led_chk   [MAX_WORDS];   // Row stores to the LED address
    logic [31:0] led_exp   [MAX_WORDS];
    int          n_words;
    int          n_prog;                  // Rows that must commit
    int          n_errors;
    int          n_checks;
    int          n_commits;

    core_top dut_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_imem_we     (i_imem_we),
        .i_imem_addr   (i_imem_addr),
        .i_imem_wdata  (i_imem_wdata),
        .o_io_ledr     (o_io_ledr),
        .o_pc_frontend (o_pc_frontend),
        .o_pc_commit   (o_pc_commit),
        .o_insn_vld    (o_insn_vld),
        .o_halt        (o_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), F3_WORD, imm[4:0], OPC_ST};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), OPC_LUI};
    endfunction

    task automatic append_insn(input logic [31:0] word);
        prog_word[n_words] = word;
        led_chk[n_words]   = 1'b0;
        led_exp[n_words]   = '0;
        n_words++;
    endtask

    // SW rs2, 0(x1) with x1 holding the LED address
    task automatic led_store(input int rs2, input logic [31:0] value);
        prog_word[n_words] = stype(12'h000, rs2, 1);
        led_chk[n_words]   = 1'b1;
        led_exp[n_words]   = value;
        n_words++;
    endtask

    task automatic alu_to_led(input logic [31:0] word, input logic [31:0] value);
        append_insn(word);   // Result lands in x10
        led_store(10, value);
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_errors++;
        $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    endtask

    // --------------------------------------------------
    // Program, straight line with no branches
    // --------------------------------------------------
    task automatic build_program();
        n_words = 0;
        append_insn(utype(LED_ADDR[31:12], 1));                      // x1 = LED address
        append_insn(itype(OPC_IMM, F3_ADD, 2, 0, HALT_ADDR[11:0]));  // x2 = halt address
        append_insn(itype(OPC_IMM, F3_ADD, 3, 0, 12'h055));          // x3 = 85
        append_insn(itype(OPC_IMM, F3_ADD, 4, 0, 12'hFF0));          // x4 = -16
        append_insn(itype(OPC_IMM, F3_ADD, 5, 0, 12'h003));          // x5 = 3
        // Register forms, store data taken from EX/MEM
        alu_to_led(rtype(F7_BASE, F3_ADD,  10, 3, 4), 32'h0000_0045);
        alu_to_led(rtype(F7_ALT,  F3_ADD,  10, 3, 4), 32'h0000_0065);  // SUB
        alu_to_led(rtype(F7_BASE, F3_AND,  10, 3, 4), 32'h0000_0050);
        alu_to_led(rtype(F7_BASE, F3_OR,   10, 3, 4), 32'hFFFF_FFF5);
        alu_to_led(rtype(F7_BASE, F3_XOR,  10, 3, 4), 32'hFFFF_FFA5);
        alu_to_led(rtype(F7_BASE, F3_SLL,  10, 3, 5), 32'h0000_02A8);
        alu_to_led(rtype(F7_BASE, F3_SR,   10, 4, 5), 32'h1FFF_FFFE);  // SRL
        alu_to_led(rtype(F7_ALT,  F3_SR,   10, 4, 5), 32'hFFFF_FFFE);  // SRA keeps the sign
        alu_to_led(rtype(F7_BASE, F3_SLT,  10, 4, 3), 32'h0000_0001);  // -16 < 85 signed
        alu_to_led(rtype(F7_BASE, F3_SLTU, 10, 4, 3), 32'h0000_0000);
        // Immediate forms
        alu_to_led(itype(OPC_IMM, F3_ADD,  10, 3, 12'hFFA), 32'h0000_004F);  // 85 - 6
        alu_to_led(itype(OPC_IMM, F3_AND,  10, 4, 12'h0FF), 32'h0000_00F0);
        alu_to_led(itype(OPC_IMM, F3_OR,   10, 3, 12'h700), 32'h0000_0755);
        alu_to_led(itype(OPC_IMM, F3_XOR,  10, 4, 12'hFFF), 32'h0000_000F);  // Bitwise NOT
        alu_to_led(itype(OPC_IMM, F3_SLL,  10, 3, 12'h004), 32'h0000_0550);
        alu_to_led(itype(OPC_IMM, F3_SR,   10, 4, 12'h004), 32'h0FFF_FFFF);
        alu_to_led(itype(OPC_IMM, F3_SR,   10, 4, 12'h402), 32'hFFFF_FFFC);  // SRAI
        alu_to_led(itype(OPC_IMM, F3_SLT,  10, 3, 12'h032), 32'h0000_0000);
        alu_to_led(itype(OPC_IMM, F3_SLTU, 10, 3, 12'hFFF), 32'h0000_0001);
        alu_to_led(utype(20'hABCDE, 10), 32'hABCD_E000);
        // Dependent chains
        append_insn(itype(OPC_IMM, F3_ADD, 11, 5, 12'h007));   // x11 = 10
        append_insn(itype(OPC_IMM, F3_ADD, 12, 11, 12'h005));  // x12 = 15 via EX/MEM
        append_insn(rtype(F7_BASE, F3_ADD, 13, 11, 12));       // x13 = 25 from both paths
        led_store(13, 32'd25);
        append_insn(itype(OPC_IMM, F3_ADD, 14, 0, 12'h001));
        append_insn(itype(OPC_IMM, F3_ADD, 14, 14, 12'h002));  // x14 = 3
        append_insn(rtype(F7_BASE, F3_ADD, 15, 14, 14));       // Newer x14 wins so 6
        led_store(15, 32'd6);
        append_insn(rtype(F7_ALT, F3_ADD, 19, 13, 14));        // x14 through the RF bypass
        led_store(19, 32'd22);
        // Load then immediate use
        append_insn(stype(12'h100, 13, 0));
        append_insn(itype(OPC_LD, F3_WORD, 16, 0, 12'h100));
        append_insn(rtype(F7_BASE, F3_ADD, 17, 16, 5));        // One bubble expected
        led_store(17, 32'd28);
        // Writes to x0 are dropped
        append_insn(itype(OPC_IMM, F3_ADD, 0, 3, 12'h7FF));
        led_store(0, 32'd0);
        append_insn(rtype(F7_BASE, F3_ADD, 18, 0, 3));
        led_store(18, 32'h0000_0055);
        append_insn(stype(12'h000, 0, 2));                     // Halt store ends the program
        n_prog = n_words;
        repeat (PAD_WORDS) append_insn(stype(12'h000, 4, 1));  // Would overwrite the LED
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] exp_pc;
        logic [31:0] led_now;
        logic [31:0] fe_hold;
        int          idx;
        i_reset      = 1'b0;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_wdata = '0;
        n_errors     = 0;
        n_checks     = 0;
        n_commits    = 0;
        build_program();
        for (int k = 0; k < n_words; k++) begin   // Load while in reset
            @(negedge i_clk);
            i_imem_we    = 1'b1;
            i_imem_addr  = IMEM_AW'(k);
            i_imem_wdata = prog_word[k];
        end
        @(negedge i_clk);
        i_imem_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        n_checks++;
        if (o_insn_vld !== 1'b0 || o_halt !== 1'b0)
            flag_mismatch("status in reset", {30'd0, o_halt, o_insn_vld}, 32'd0);
        n_checks++;
        if (o_io_ledr !== 32'd0) flag_mismatch("LED in reset", o_io_ledr, 32'd0);
        i_reset = 1'b1;

        exp_pc  = '0;
        led_now = '0;
        do begin
            @(negedge i_clk);
            if (o_insn_vld) begin
                if (n_commits >= n_prog) begin
                    n_errors++;
                    $display("Commit after the halt store at t=%0t, pc 0x%08h", $time,
                             o_pc_commit);
                end else begin
                    idx = n_commits;
                    if (led_chk[idx]) led_now = led_exp[idx];
                    n_checks++;
                    if (o_pc_commit !== exp_pc) flag_mismatch("commit PC", o_pc_commit, exp_pc);
                    n_checks++;
                    if (o_io_ledr !== led_now) flag_mismatch("LED value", o_io_ledr, led_now);
                end
                n_commits++;
                exp_pc = exp_pc + 32'd4;   // One word per commit
            end
        end while (!o_halt);

        n_checks++;
        if (n_commits != n_prog) flag_mismatch("commit count", 32'(n_commits), 32'(n_prog));
        // Halt store PC plus four words, the fetch that entered IF/ID as o_halt rose
        fe_hold = 32'(4 * (n_prog + 3));
        repeat (POST_HALT) begin   // Core must stay frozen
            @(negedge i_clk);
            n_checks++;
            if (o_insn_vld !== 1'b0) flag_mismatch("valid after halt", 32'(o_insn_vld), 32'd0);
            n_checks++;
            if (o_halt !== 1'b1) flag_mismatch("halt level", 32'(o_halt), 32'd1);
            n_checks++;
            if (o_io_ledr !== led_now) flag_mismatch("LED after halt", o_io_ledr, led_now);
            n_checks++;
            if (o_pc_frontend !== fe_hold)
                flag_mismatch("front-end PC after halt", o_pc_frontend, fe_hold);
        end

        $display("Checks: %0d  errors: %0d  commits: %0d", n_checks, n_errors, n_commits);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, program length plus margin
    initial begin
        wait (i_reset === 1'b1);
        repeat (n_words + 40) @(posedge i_clk);
        $display("Timeout: the halt store was never reached after %0d cycles", n_words + 40);
        $display("Checks: %0d  errors: %0d  commits: %0d", n_checks, n_errors, n_commits);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hazard_unit.sv
hw/core_top.sv
test/tb_core_top.sv
